/* common/guess_pkg.sv */
package guess_pkg;

	// timing, for a 50 MHz board clock.
	localparam int SCAN_TICKS     = 50000;  // 1 ms per digit.
	localparam int DEBOUNCE_TICKS = 250000; // 5 ms of steady level.

	// try counter saturates at 99.
	localparam int TRIES_MAX_TENS = 9;
	localparam int TRIES_MAX_ONES = 9;

	localparam int NUM_DIGITS = 4;

	typedef logic [3:0]                    digit_t;    // one bcd digit.
	typedef logic [7:0]                    seg_t;      // bit 0 is segment a, bit 7 the dp.
	typedef logic [NUM_DIGITS-1:0]         sel_t;      // active low, bit 0 rightmost.
	typedef logic [$clog2(NUM_DIGITS)-1:0] scan_idx_t;
	typedef logic [1:0]                    hint_t;

	localparam hint_t HINT_NONE = 2'd0;
	localparam hint_t HINT_HIGH = 2'd1;
	localparam hint_t HINT_LOW  = 2'd2;
	localparam hint_t HINT_WIN  = 2'd3;

	// glyphs, segments active high.
	localparam seg_t SEG_0 = 8'h3f;
	localparam seg_t SEG_1 = 8'h06;
	localparam seg_t SEG_2 = 8'h5b;
	localparam seg_t SEG_3 = 8'h4f;
	localparam seg_t SEG_4 = 8'h66;
	localparam seg_t SEG_5 = 8'h6d;
	localparam seg_t SEG_6 = 8'h7d;
	localparam seg_t SEG_7 = 8'h07;
	localparam seg_t SEG_8 = 8'h7f;
	localparam seg_t SEG_9 = 8'h6f;

	localparam seg_t SEG_H     = 8'h76;
	localparam seg_t SEG_L     = 8'h38;
	localparam seg_t SEG_DASH  = 8'h40; // segment g only.
	localparam seg_t SEG_BLANK = 8'h00;

	typedef enum logic [1:0]
	{
		IDLE, // no secret yet.
		PLAY,
		WON
	} game_state_t;

endpackage

/* display/digit_scan.sv */
module digit_scan
(
	input  logic              CLK,
	input  logic              rst_n,
	input  guess_pkg::hint_t  hint,
	input  guess_pkg::digit_t secret,
	input  guess_pkg::digit_t tries_tens,
	input  guess_pkg::digit_t tries_ones,
	output guess_pkg::seg_t   segments,
	output guess_pkg::sel_t   digit_sel
);
	import guess_pkg::*;

	logic [$clog2(SCAN_TICKS)-1:0] ms_cnt;
	logic                          ms_tick;
	scan_idx_t                     scan_idx;
	seg_t                          hint_glyph;

	function automatic seg_t digit_glyph(input digit_t d);
		case (d)
			4'd0:    return SEG_0;
			4'd1:    return SEG_1;
			4'd2:    return SEG_2;
			4'd3:    return SEG_3;
			4'd4:    return SEG_4;
			4'd5:    return SEG_5;
			4'd6:    return SEG_6;
			4'd7:    return SEG_7;
			4'd8:    return SEG_8;
			4'd9:    return SEG_9;
			default: return SEG_BLANK;
		endcase
	endfunction

	assign ms_tick = (ms_cnt == SCAN_TICKS - 1);

	// scan period timer.
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
			ms_cnt <= '0;
		else if (ms_tick)
			ms_cnt <= '0;
		else
			ms_cnt <= ms_cnt + 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
			scan_idx <= '0;
		else if (ms_tick)
		begin
			if (scan_idx == scan_idx_t'(NUM_DIGITS - 1))
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end
	end

	// one select low, index 0 is the rightmost digit.
	assign digit_sel = ~(sel_t'(1) << scan_idx);

	always_comb
	begin
		case (hint)
			HINT_HIGH: hint_glyph = SEG_H;
			HINT_LOW:  hint_glyph = SEG_L;
			HINT_WIN:  hint_glyph = digit_glyph(secret); // show the found digit.
			default:   hint_glyph = SEG_DASH;
		endcase
	end

	always_comb
	begin
		case (scan_idx)
			2'd0:    segments = digit_glyph(tries_ones);
			2'd1:    segments = digit_glyph(tries_tens);
			2'd3:    segments = hint_glyph;
			default: segments = SEG_BLANK; // digit 2 stays dark.
		endcase
	end

	// the low select steps one digit left on each tick.
	a_sel_step: assert property (@(posedge CLK) disable iff (!rst_n)
		ms_tick |=> (digit_sel == {$past(digit_sel[NUM_DIGITS-2:0]),
			$past(digit_sel[NUM_DIGITS-1])}));

endmodule

/* dv/tb_guess_top.sv */
module tb_guess_top;
	timeunit 1ns;
	timeprecision 1ps;

	import guess_pkg::*;

	localparam int NUM_TESTS      = 9;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * DEBOUNCE_TICKS + 6 * SCAN_TICKS + 100);

	logic   CLK;
	logic   rst_n;
	logic   key_set_n;
	logic   key_guess_n;
	digit_t switches;
	seg_t   segments;
	sel_t   digit_sel;

	int   err_count  = 0;
	int   pass_count = 0;
	int   fail_count = 0;
	int   cycle_cnt  = 0;
	seg_t shown_ones;
	seg_t shown_tens;
	seg_t shown_blank;
	seg_t shown_hint;

	// one row per key press.
	string  test_name[$] = '{"guess_no_secret", "set_6", "guess_8_high", "guess_2_low",
		"guess_6_win", "guess_1_frozen", "set_12_clamp", "guess_15_win", "guess_3_after_win"};
	bit     is_set[$]    = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	digit_t sw_value[$]  = '{4'd5, 4'd6, 4'd8, 4'd2, 4'd6, 4'd1, 4'd12, 4'd15, 4'd3};
	seg_t   exp_hint[$]  = '{SEG_DASH, SEG_DASH, SEG_H, SEG_L, SEG_6, SEG_6, SEG_DASH,
		SEG_9, SEG_9};
	seg_t   exp_tens[$]  = '{SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0};
	seg_t   exp_ones[$]  = '{SEG_0, SEG_0, SEG_1, SEG_2, SEG_3, SEG_3, SEG_0, SEG_1, SEG_1};

	guess_top i_dut
	(
		.CLK         (CLK),
		.rst_n       (rst_n),
		.key_set_n   (key_set_n),
		.key_guess_n (key_guess_n),
		.switches    (switches),
		.segments    (segments),
		.digit_sel   (digit_sel)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// hard stop for a stuck run.
	always @(posedge CLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// select pattern for a scan index, low bit is the shown digit.
	function automatic sel_t sel_for_index(input scan_idx_t i);
		case (i)
			2'd0:    return 4'b1110;
			2'd1:    return 4'b1101;
			2'd2:    return 4'b1011;
			default: return 4'b0111;
		endcase
	endfunction

	function automatic scan_idx_t low_index(input sel_t s);
		case (s)
			4'b1101: return 2'd1;
			4'b1011: return 2'd2;
			4'b0111: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic check_sel(input string name, input sel_t expected, input sel_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %b, got %b", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[FAIL] %s: expected %0d low selects, got %0d", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic drive_key(input bit use_set, input logic level);
		if (use_set)
			key_set_n <= level;
		else
			key_guess_n <= level;
	endtask

	// short bounces first, then a clean press and release.
	task automatic press_key(input bit use_set, input digit_t value);
		int glitches;
		@(posedge CLK);
		switches <= value;
		glitches = int'($urandom_range(3, 0));
		repeat (glitches)
		begin
			@(posedge CLK);
			drive_key(use_set, 1'b0);
			repeat (int'($urandom_range(6, 1))) @(posedge CLK);
			drive_key(use_set, 1'b1);
			repeat (int'($urandom_range(6, 1))) @(posedge CLK);
		end
		@(posedge CLK);
		drive_key(use_set, 1'b0);
		repeat (DEBOUNCE_TICKS + 10) @(posedge CLK);
		drive_key(use_set, 1'b1);
		repeat (DEBOUNCE_TICKS + 10) @(posedge CLK);
	endtask

	task automatic store_digit(input scan_idx_t idx, input seg_t value);
		case (idx)
			2'd0:    shown_ones  = value;
			2'd1:    shown_tens  = value;
			2'd2:    shown_blank = value;
			default: shown_hint  = value;
		endcase
	endtask

	// one full scan cycle, sampled on the falling edge.
	task automatic capture_display(input string name);
		scan_idx_t idx;
		sel_t      prev;
		@(negedge CLK);
		idx = low_index(digit_sel) + 1'b1;
		while (digit_sel !== sel_for_index(idx))
			@(negedge CLK);
		for (int k = 0; k < NUM_DIGITS; k++)
		begin
			if (k > 0)
			begin
				prev = digit_sel;
				while (digit_sel === prev)
					@(negedge CLK);
				idx = idx + 1'b1;
				check_sel({name, " select"}, sel_for_index(idx), digit_sel);
			end
			check_count({name, " select"}, 1, $countones(~digit_sel));
			store_digit(low_index(digit_sel), segments);
		end
	endtask

	task automatic check_digits(input string name, input seg_t hint_g, input seg_t tens_g,
		input seg_t ones_g);
		check_seg({name, " digit3"}, hint_g, shown_hint);
		check_seg({name, " digit2"}, SEG_BLANK, shown_blank);
		check_seg({name, " digit1"}, tens_g, shown_tens);
		check_seg({name, " digit0"}, ones_g, shown_ones);
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (err_count == err_before)
		begin
			pass_count++;
			$display("%-18s ok", name);
		end
		else
		begin
			fail_count++;
			$display("%-18s %0d mismatches", name, err_count - err_before);
		end
	endtask

	initial
	begin
		int err_before;
		void'($urandom(63667));
		rst_n       = 1'b0;
		key_set_n   = 1'b1;
		key_guess_n = 1'b1;
		switches    = '0;
		repeat (16) @(posedge CLK);
		rst_n <= 1'b1;

		@(negedge CLK);
		err_before = err_count;
		check_sel("reset_state select", sel_for_index(2'd0), digit_sel);
		capture_display("reset_state");
		check_digits("reset_state", SEG_DASH, SEG_0, SEG_0);
		finish_test("reset_state", err_before);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			err_before = err_count;
			press_key(is_set[t], sw_value[t]);
			capture_display(test_name[t]);
			check_digits(test_name[t], exp_hint[t], exp_tens[t], exp_ones[t]);
			finish_test(test_name[t], err_before);
		end

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* game/guess_game.sv */
module guess_game
(
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              set_press,
	input  logic              guess_press,
	input  guess_pkg::digit_t switches,
	output guess_pkg::hint_t  hint,
	output guess_pkg::digit_t secret,
	output guess_pkg::digit_t tries_tens,
	output guess_pkg::digit_t tries_ones
);
	import guess_pkg::*;

	game_state_t state;
	digit_t      guess;
	digit_t      next_tens;
	digit_t      next_ones;
	logic        tries_full;

	// switch values above 9 read as 9.
	function automatic digit_t clamp_digit(input digit_t v);
		if (v > 4'd9)
			return 4'd9;
		return v;
	endfunction

	assign guess = clamp_digit(switches);

	assign tries_full = (tries_tens == digit_t'(TRIES_MAX_TENS))
		&& (tries_ones == digit_t'(TRIES_MAX_ONES));

	// bcd increment of the try count.
	always_comb
	begin
		next_tens = tries_tens;
		next_ones = tries_ones;
		if (!tries_full)
		begin
			if (tries_ones == 4'd9)
			begin
				next_ones = 4'd0;
				next_tens = tries_tens + 4'd1;
			end
			else
				next_ones = tries_ones + 4'd1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			state      <= IDLE;
			hint       <= HINT_NONE;
			secret     <= 4'd0;
			tries_tens <= 4'd0;
			tries_ones <= 4'd0;
		end
		else if (set_press)
		begin
			// a new secret restarts the round from any state.
			state      <= PLAY;
			hint       <= HINT_NONE;
			secret     <= guess;
			tries_tens <= 4'd0;
			tries_ones <= 4'd0;
		end
		else if (guess_press)
		begin
			case (state)
				PLAY:
				begin
					tries_tens <= next_tens;
					tries_ones <= next_ones;
					if (guess > secret)
						hint <= HINT_HIGH;
					else if (guess < secret)
						hint <= HINT_LOW;
					else
					begin
						hint  <= HINT_WIN;
						state <= WON;
					end
				end
				default:
				begin
					state <= state; // idle and won ignore guesses.
				end
			endcase
		end
	end

	a_tries_bcd: assert property (@(posedge CLK) disable iff (!rst_n)
		(tries_tens <= 4'd9) && (tries_ones <= 4'd9));

	a_win_state: assert property (@(posedge CLK) disable iff (!rst_n)
		(hint == HINT_WIN) == (state == WON));

endmodule

/* rtl/guess_top.sv */
module guess_top
(
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              key_set_n,
	input  logic              key_guess_n,
	input  guess_pkg::digit_t switches,
	output guess_pkg::seg_t   segments,
	output guess_pkg::sel_t   digit_sel
);
	import guess_pkg::*;

	logic   set_press;
	logic   guess_press;
	hint_t  hint;
	digit_t secret;
	digit_t tries_tens;
	digit_t tries_ones;

	key_debounce i_set_key
	(
		.CLK   (CLK),
		.rst_n (rst_n),
		.key_n (key_set_n),
		.press (set_press)
	);

	key_debounce i_guess_key
	(
		.CLK   (CLK),
		.rst_n (rst_n),
		.key_n (key_guess_n),
		.press (guess_press)
	);

	// switches go straight in, sampled on the press pulse.
	guess_game i_game
	(
		.CLK         (CLK),
		.rst_n       (rst_n),
		.set_press   (set_press),
		.guess_press (guess_press),
		.switches    (switches),
		.hint        (hint),
		.secret      (secret),
		.tries_tens  (tries_tens),
		.tries_ones  (tries_ones)
	);

	digit_scan i_scan
	(
		.CLK        (CLK),
		.rst_n      (rst_n),
		.hint       (hint),
		.secret     (secret),
		.tries_tens (tries_tens),
		.tries_ones (tries_ones),
		.segments   (segments),
		.digit_sel  (digit_sel)
	);

endmodule

/* rtl/key_debounce.sv */
module key_debounce
(
	input  logic CLK,
	input  logic rst_n,
	input  logic key_n,
	output logic press
);
	import guess_pkg::*;

	logic [$clog2(DEBOUNCE_TICKS)-1:0] cnt;
	logic                              key_meta;
	logic                              key_sync;
	logic                              key_level; // accepted level, 1 is released.
	logic                              settled;

	assign settled = (cnt == DEBOUNCE_TICKS - 1);

	// two flop synchronizer.
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end
		else
		begin
			key_meta <= key_n;
			key_sync <= key_meta;
		end
	end

	// count while the input disagrees with the accepted level.
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			cnt       <= '0;
			key_level <= 1'b1;
			press     <= 1'b0;
		end
		else
		begin
			press <= 1'b0;
			if (key_sync == key_level)
				cnt <= '0; // a bounce lands here and restarts.
			else if (settled)
			begin
				cnt       <= '0;
				key_level <= key_sync;
				press     <= !key_sync; // only the falling side counts.
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	a_press_single: assert property (@(posedge CLK) disable iff (!rst_n)
		press |=> !press);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the guess_top simulation with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_guess_top \
	-f verilog.f \
	-o sim_guess
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_guess > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

exit 0

/* verilog.f */
common/guess_pkg.sv
rtl/key_debounce.sv
game/guess_game.sv
display/digit_scan.sv
rtl/guess_top.sv
dv/tb_guess_top.sv
